/* chip8_panel_settings.svh */
`ifndef CHIP8_PANEL_SETTINGS_SVH
`define CHIP8_PANEL_SETTINGS_SVH

// cycle counts below assume the 100 MHz board clock

// run mode tick, 500 Hz
`define CHIP8_TICK_CYCLES 200000

// one debug read every 10 ms
`define DEBUG_POLL_CYCLES 1000000

// 5 ms of stable input before the debouncer output follows
`define DEBOUNCE_CYCLES 500000

// 1 ms per digit, full refresh every 8 ms
`define SEG_SCAN_CYCLES 100000

`define SEG_DIGITS 8 // digits on the board, upper four and lower four

// flops ahead of the debounce counter
`define SYNC_STAGES 2

`endif

/* panel_pkg.sv */
`default_nettype none

`include "chip8_panel_settings.svh"

// types for the switches, leds and seven segment display
package panel_pkg;

  // one bit per slide switch, also the chip8 key map
  typedef logic [15:0] key_vec_t;

  // cathodes, active low, bit 0 is segment a and bit 6 is segment g
  typedef logic [6:0] seg_t;

  // anodes, active low, one bit per digit
  typedef logic [`SEG_DIGITS-1:0] anode_t;

  // single hex digit
  typedef logic [3:0] nibble_t;

endpackage

`default_nettype wire

/* dbg_mem_pkg.sv */
`default_nettype none

// types for the debug read port of the chip8 memory
package dbg_mem_pkg;

  // 4 KiB chip8 address space
  typedef logic [11:0] mem_addr_t;

  typedef logic [15:0] mem_word_t; // read data, up to two bytes

  // which memory the debug port reads from
  typedef enum logic [1:0] {
    MEM_RAM  = 2'd0, // main ram
    MEM_VRAM = 2'd1, // frame buffer
    MEM_REG  = 2'd2, // V0..VF and friends
    MEM_STK  = 2'd3  // call stack
  } mem_type_e;

endpackage

`default_nettype wire

/* debouncer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "chip8_panel_settings.svh"

// synchronizes a whole payload and releases it only after it has been
// stable for CYCLES clocks
module debouncer #(
  parameter type         T      = logic,
  parameter int unsigned CYCLES = `DEBOUNCE_CYCLES
) (
  input  wire  clk_100mhz_buf,
  input  wire  sys_rst,
  input  T     raw,
  output T     clean
);

  localparam int CW = $clog2(CYCLES + 1);

  T            sync_q [`SYNC_STAGES]; // synchronizer chain
  T            prev_q;                // last synchronized value
  logic [CW-1:0] stable_cnt;          // cycles without change

  always_ff @(posedge clk_100mhz_buf) begin
    if (sys_rst) begin
      for (int i = 0; i < `SYNC_STAGES; i++) begin
        sync_q[i] <= T'(0);
      end
      prev_q     <= T'(0);
      stable_cnt <= '0;
      clean      <= T'(0);
    end else begin
      sync_q[0] <= raw;
      for (int i = 1; i < `SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      prev_q <= sync_q[`SYNC_STAGES-1];

      if (sync_q[`SYNC_STAGES-1] != prev_q) begin
        stable_cnt <= '0; // any bit moved, start over
      end else if (stable_cnt == CW'(CYCLES)) begin
        clean <= prev_q; // held long enough
      end else begin
        stable_cnt <= stable_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* step_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "chip8_panel_settings.svh"

// chip8 instruction tick
// run mode: one pulse every TICK_CYCLES clocks
// step mode: one pulse per press of the (debounced) step button
module step_clock_gen #(
  parameter int unsigned TICK_CYCLES = `CHIP8_TICK_CYCLES
) (
  input  wire  clk_100mhz_buf,
  input  wire  sys_rst,
  input  wire  step_mode,
  input  wire  step_held,
  output logic chip8_tick
);

  localparam int CW = $clog2(TICK_CYCLES + 1);

  logic [CW-1:0] div_cnt;
  logic          step_held_q; // for edge detect

  always_ff @(posedge clk_100mhz_buf) begin
    if (sys_rst) begin
      div_cnt     <= '0;
      step_held_q <= 1'b0;
      chip8_tick  <= 1'b0;
    end else begin
      // tracked in both modes so a mode change does not fake an edge
      step_held_q <= step_held;

      if (step_mode) begin
        div_cnt    <= '0; // divider parked while stepping
        chip8_tick <= step_held & ~step_held_q;
      end else if (div_cnt == CW'(TICK_CYCLES - 1)) begin
        div_cnt    <= '0;
        chip8_tick <= 1'b1;
      end else begin
        div_cnt    <= div_cnt + 1'b1;
        chip8_tick <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* debug_mem_poller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "chip8_panel_settings.svh"

// periodically reads the memory word selected by the switches and keeps
// the last answer for the display
module debug_mem_poller #(
  parameter int unsigned POLL_CYCLES = `DEBUG_POLL_CYCLES
) (
  input  wire                     clk_100mhz_buf,
  input  wire                     sys_rst,
  input  panel_pkg::key_vec_t     key_state,
  input  wire                     dbg_mem_ready,
  input  wire                     dbg_mem_resp,
  input  dbg_mem_pkg::mem_word_t  dbg_mem_data,
  output logic                    dbg_mem_req,
  output dbg_mem_pkg::mem_addr_t  dbg_mem_addr,
  output dbg_mem_pkg::mem_type_e  dbg_mem_type,
  output logic [31:0]             disp_value
);

  import dbg_mem_pkg::*;

  localparam int CW = $clog2(POLL_CYCLES + 1);

  logic [CW-1:0] poll_cnt;
  mem_word_t     data_q; // last returned word

  always_ff @(posedge clk_100mhz_buf) begin
    if (sys_rst) begin
      poll_cnt     <= '0;
      dbg_mem_req  <= 1'b0;
      dbg_mem_addr <= '0;
      dbg_mem_type <= MEM_RAM;
    end else begin
      dbg_mem_req <= 1'b0; // single cycle pulse
      if (poll_cnt == CW'(POLL_CYCLES - 1)) begin
        poll_cnt <= '0;
        // memory busy means this poll is simply dropped
        if (dbg_mem_ready) begin
          dbg_mem_req  <= 1'b1;
          dbg_mem_addr <= key_state[11:0];
          dbg_mem_type <= mem_type_e'(key_state[15:14]);
        end
      end else begin
        poll_cnt <= poll_cnt + 1'b1;
      end
    end
  end

  // any response counts, there is only ever one read in flight
  always_ff @(posedge clk_100mhz_buf) begin
    if (sys_rst) begin
      data_q <= '0;
    end else if (dbg_mem_resp) begin
      data_q <= dbg_mem_data;
    end
  end

  // upper digits: type and address, lower digits: data
  assign disp_value = {2'b00, dbg_mem_type, dbg_mem_addr, data_q};

endmodule

`default_nettype wire

/* seven_seg_driver.sv */
`timescale 1ns/1ps
`default_nettype none

`include "chip8_panel_settings.svh"

// scanned hex display, digit 0 is the rightmost (least significant nibble)
module seven_seg_driver #(
  parameter int unsigned SCAN_CYCLES = `SEG_SCAN_CYCLES
) (
  input  wire               clk_100mhz_buf,
  input  wire               sys_rst,
  input  wire  [31:0]       value,
  output panel_pkg::seg_t   ss_c,
  output panel_pkg::anode_t ss_an
);

  import panel_pkg::*;

  localparam int CW = $clog2(SCAN_CYCLES + 1);
  localparam int DW = $clog2(`SEG_DIGITS);

  logic [CW-1:0] scan_cnt;
  logic [DW-1:0] digit;   // currently lit digit
  nibble_t       nibble;

  // hex digit to cathodes, active low, bit 0 = segment a
  function automatic seg_t hex_to_seg(input nibble_t n);
    case (n)
      4'h0:    return ~7'h3F;
      4'h1:    return ~7'h06;
      4'h2:    return ~7'h5B;
      4'h3:    return ~7'h4F;
      4'h4:    return ~7'h66;
      4'h5:    return ~7'h6D;
      4'h6:    return ~7'h7D;
      4'h7:    return ~7'h07;
      4'h8:    return ~7'h7F;
      4'h9:    return ~7'h6F;
      4'hA:    return ~7'h77;
      4'hB:    return ~7'h7C; // lower case b
      4'hC:    return ~7'h39;
      4'hD:    return ~7'h5E; // lower case d
      4'hE:    return ~7'h79;
      default: return ~7'h71;
    endcase
  endfunction

  always_ff @(posedge clk_100mhz_buf) begin
    if (sys_rst) begin
      scan_cnt <= '0;
      digit    <= '0;
    end else if (scan_cnt == CW'(SCAN_CYCLES - 1)) begin
      scan_cnt <= '0;
      if (digit == DW'(`SEG_DIGITS - 1)) begin
        digit <= '0; // wrap to the rightmost digit
      end else begin
        digit <= digit + 1'b1;
      end
    end else begin
      scan_cnt <= scan_cnt + 1'b1;
    end
  end

  assign nibble = value[digit*4 +: 4];
  assign ss_c   = hex_to_seg(nibble);
  assign ss_an  = ~(anode_t'(1) << digit); // exactly one anode pulled low

endmodule

`default_nettype wire

/* chip8_panel_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "chip8_panel_settings.svh"

// chip8 debug front panel: switches, instruction tick, memory peek, display
module chip8_panel_top #(
  parameter int unsigned TICK_CYCLES     = `CHIP8_TICK_CYCLES,
  parameter int unsigned POLL_CYCLES     = `DEBUG_POLL_CYCLES,
  parameter int unsigned DEBOUNCE_CYCLES = `DEBOUNCE_CYCLES,
  parameter int unsigned SCAN_CYCLES     = `SEG_SCAN_CYCLES
) (
  input  wire                     clk_100mhz_buf,
  input  wire                     sys_rst,

  input  panel_pkg::key_vec_t     sw,        // slide switches
  input  wire                     step_btn,  // raw step button
  input  wire                     step_mode, // 1 = single step

  input  wire                     dbg_mem_ready,
  input  wire                     dbg_mem_resp,
  input  dbg_mem_pkg::mem_word_t  dbg_mem_data,

  output panel_pkg::key_vec_t     led,
  output panel_pkg::key_vec_t     key_state, // to the processor
  output logic                    chip8_tick,

  output logic                    dbg_mem_req,
  output dbg_mem_pkg::mem_addr_t  dbg_mem_addr,
  output dbg_mem_pkg::mem_type_e  dbg_mem_type,

  output panel_pkg::seg_t         ss_c,
  output panel_pkg::anode_t       ss_an
);

  import panel_pkg::*;

  key_vec_t    keys_clean; // debounced switches
  logic        step_held;
  logic [31:0] disp_value; // last poll for the display

  // whole switch vector debounced as one value
  debouncer #(
    .T      (key_vec_t),
    .CYCLES (DEBOUNCE_CYCLES)
  ) key_db (
    .clk_100mhz_buf (clk_100mhz_buf),
    .sys_rst        (sys_rst),
    .raw            (sw),
    .clean          (keys_clean)
  );

  debouncer #(
    .T      (logic),
    .CYCLES (DEBOUNCE_CYCLES)
  ) btn_db (
    .clk_100mhz_buf (clk_100mhz_buf),
    .sys_rst        (sys_rst),
    .raw            (step_btn),
    .clean          (step_held)
  );

  assign led       = keys_clean;
  assign key_state = keys_clean;

  step_clock_gen #(
    .TICK_CYCLES (TICK_CYCLES)
  ) tick_gen (
    .clk_100mhz_buf (clk_100mhz_buf),
    .sys_rst        (sys_rst),
    .step_mode      (step_mode),
    .step_held      (step_held),
    .chip8_tick     (chip8_tick)
  );

  // address from sw[11:0], memory type from sw[15:14]
  debug_mem_poller #(
    .POLL_CYCLES (POLL_CYCLES)
  ) poller (
    .clk_100mhz_buf (clk_100mhz_buf),
    .sys_rst        (sys_rst),
    .key_state      (keys_clean),
    .dbg_mem_ready  (dbg_mem_ready),
    .dbg_mem_resp   (dbg_mem_resp),
    .dbg_mem_data   (dbg_mem_data),
    .dbg_mem_req    (dbg_mem_req),
    .dbg_mem_addr   (dbg_mem_addr),
    .dbg_mem_type   (dbg_mem_type),
    .disp_value     (disp_value)
  );

  seven_seg_driver #(
    .SCAN_CYCLES (SCAN_CYCLES)
  ) seg_drv (
    .clk_100mhz_buf (clk_100mhz_buf),
    .sys_rst        (sys_rst),
    .value          (disp_value),
    .ss_c           (ss_c),
    .ss_an          (ss_an)
  );

endmodule

`default_nettype wire

/* chip8_panel_sva.sv */
`timescale 1ns/1ps
`default_nettype none

`include "chip8_panel_settings.svh"

// protocol rules of the panel top level
module chip8_panel_sva (
  input  wire               clk_100mhz_buf,
  input  wire               sys_rst,
  input  wire               chip8_tick,
  input  wire               dbg_mem_req,
  input  wire               dbg_mem_ready,
  input  panel_pkg::anode_t ss_an
);

  // single cycle strobe in run and step mode alike
  tick_single_cycle: assert property (
    @(posedge clk_100mhz_buf) disable iff (sys_rst)
    chip8_tick |=> !chip8_tick
  ) else $error("chip8_tick stayed high for two cycles");

  req_needs_ready: assert property (
    @(posedge clk_100mhz_buf) disable iff (sys_rst)
    dbg_mem_req |-> dbg_mem_ready
  ) else $error("dbg_mem_req raised while dbg_mem_ready was low");

  // active low anodes with exactly one lit digit that moves on one place at a time
  one_digit_lit: assert property (
    @(posedge clk_100mhz_buf) disable iff (sys_rst)
    $onehot(~ss_an) &&
    (ss_an == $past(ss_an) ||
     ss_an == {$past(ss_an[`SEG_DIGITS-2:0]), $past(ss_an[`SEG_DIGITS-1])})
  ) else $error("ss_an 0x%h does not enable exactly one digit in scan order", ss_an);

endmodule

bind chip8_panel_top chip8_panel_sva sva_chk (
  .clk_100mhz_buf (clk_100mhz_buf),
  .sys_rst        (sys_rst),
  .chip8_tick     (chip8_tick),
  .dbg_mem_req    (dbg_mem_req),
  .dbg_mem_ready  (dbg_mem_ready),
  .ss_an          (ss_an)
);

`default_nettype wire

/* tb_chip8_panel_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "chip8_panel_settings.svh"

module tb_chip8_panel_top;

  import panel_pkg::*;
  import dbg_mem_pkg::*;

  localparam int TICK = 20;
  localparam int POLL = 40;
  localparam int DEB = 8;
  localparam int SCAN = 4;
  localparam int RESET_CYCLES = 4;
  localparam int PRESS_CYCLES = 20; // step button held and then released for this long
  localparam int DEB_LIMIT = `SYNC_STAGES + DEB + 2; // worst case debounce latency
  localparam int SEL_TICK = 0;
  localparam int SEL_REQ = 1;
  localparam int SEL_RESP = 2;
  // upper bound of all tests together in cycles
  localparam int TEST_CYCLES = (RESET_CYCLES + 4) + (DEB_LIMIT + 14 + 3 * (DEB_LIMIT + 3))
    + (6 * TICK + 6 * PRESS_CYCLES + 8) + (2 * (DEB_LIMIT + 5 + 3 * POLL) + 4 * POLL + 8)
    + 2 * (DEB_LIMIT + 8 + 2 * POLL + 8 * SCAN);

  logic        clk_100mhz_buf = 1'b0;
  logic        sys_rst, step_btn, step_mode, dbg_mem_ready;
  logic        dbg_mem_resp = 1'b0; // memory model outputs
  mem_word_t   dbg_mem_data = '0;
  key_vec_t    sw, led, key_state;
  logic        chip8_tick, dbg_mem_req;
  mem_addr_t   dbg_mem_addr;
  mem_type_e   dbg_mem_type;
  seg_t        ss_c;
  anode_t      ss_an;

  logic [1:0]  req_pipe = '0;  // request delay line of the memory model
  mem_word_t   pend_word = '0;
  logic        check_req = 1'b0;
  logic        check_disp = 1'b0;
  key_vec_t    expected_keys = '0;
  logic [31:0] disp_exp = '0;
  logic [7:0]  seen_digits = '0;
  int          dig;
  integer      seed = 38060;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;

  chip8_panel_top #(
    .TICK_CYCLES     (TICK),
    .POLL_CYCLES     (POLL),
    .DEBOUNCE_CYCLES (DEB),
    .SCAN_CYCLES     (SCAN)
  ) UUT (
    .clk_100mhz_buf (clk_100mhz_buf),
    .sys_rst        (sys_rst),
    .sw             (sw),
    .step_btn       (step_btn),
    .step_mode      (step_mode),
    .dbg_mem_ready  (dbg_mem_ready),
    .dbg_mem_resp   (dbg_mem_resp),
    .dbg_mem_data   (dbg_mem_data),
    .led            (led),
    .key_state      (key_state),
    .chip8_tick     (chip8_tick),
    .dbg_mem_req    (dbg_mem_req),
    .dbg_mem_addr   (dbg_mem_addr),
    .dbg_mem_type   (dbg_mem_type),
    .ss_c           (ss_c),
    .ss_an          (ss_an)
  );

  always #5 clk_100mhz_buf = ~clk_100mhz_buf;

  // memory contents are the address with the type folded into bits 13:12
  function automatic mem_word_t expected_word(input mem_addr_t addr, input logic [1:0] typ);
    return mem_word_t'(addr) ^ (mem_word_t'(typ) << 12);
  endfunction

  function automatic seg_t hex_segments(input nibble_t n);
    logic [6:0] lit; // gfedcba with 1 for a lit segment
    case (n)
      4'h0:    lit = 7'b0111111;
      4'h1:    lit = 7'b0000110;
      4'h2:    lit = 7'b1011011;
      4'h3:    lit = 7'b1001111;
      4'h4:    lit = 7'b1100110;
      4'h5:    lit = 7'b1101101;
      4'h6:    lit = 7'b1111101;
      4'h7:    lit = 7'b0000111;
      4'h8:    lit = 7'b1111111;
      4'h9:    lit = 7'b1101111;
      4'hA:    lit = 7'b1110111;
      4'hB:    lit = 7'b1111100;
      4'hC:    lit = 7'b0111001;
      4'hD:    lit = 7'b1011110;
      4'hE:    lit = 7'b1111001;
      default: lit = 7'b1110001;
    endcase
    return ~lit; // cathodes are active low
  endfunction

  function automatic logic pulse_level(input int sel);
    case (sel)
      SEL_TICK: return chip8_tick;
      SEL_REQ:  return dbg_mem_req;
      default:  return dbg_mem_resp;
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // n = rising edges until the pulse is seen
  task automatic wait_for_pulse(input int sel, input int limit, input string what,
                                output int n);
    n = 0;
    @(negedge clk_100mhz_buf);
    while (pulse_level(sel) !== 1'b1 && n < limit) begin
      @(negedge clk_100mhz_buf);
      n++;
    end
    checks++;
    assert (pulse_level(sel) === 1'b1) else begin
      errors++;
      $display("%s never went high within %0d cycles", what, limit);
    end
  endtask

  task automatic count_pulses(input int sel, input int cycles, output int n);
    n = 0;
    repeat (cycles) begin
      @(negedge clk_100mhz_buf);
      if (pulse_level(sel) === 1'b1) n++;
    end
  endtask

  task automatic set_switches(input key_vec_t v);
    int n;
    @(posedge clk_100mhz_buf);
    sw <= v;
    @(negedge clk_100mhz_buf);
    n = 0;
    while (led !== v && n < DEB_LIMIT + 2) begin
      @(negedge clk_100mhz_buf);
      n++;
    end
    checks++;
    assert (n <= DEB_LIMIT) else begin
      errors++;
      $display("led took %0d cycles to follow sw, limit is %0d", n, DEB_LIMIT);
    end
    compare_value("led", led, v);
    compare_value("key_state", key_state, v);
  endtask

  task automatic print_result(input string name, input int err_before);
    tests_run++;
    $display("%s done, %0d errors", name, errors - err_before);
  endtask

  task automatic reset_behavior();
    int e;
    e = errors;
    for (int i = 0; i < RESET_CYCLES + 3; i++) begin
      @(posedge clk_100mhz_buf);
      if (i == RESET_CYCLES - 1) sys_rst <= 1'b0;
      @(negedge clk_100mhz_buf);
      compare_value("chip8_tick", chip8_tick, 0);
      compare_value("dbg_mem_req", dbg_mem_req, 0);
      compare_value("led", led, 0);
    end
    print_result("reset", e);
  endtask

  task automatic debounce_switches();
    int e;
    key_vec_t v;
    e = errors;
    @(posedge clk_100mhz_buf);
    sw <= 16'hA5A5;
    repeat (DEB - 2) @(posedge clk_100mhz_buf);
    sw <= '0; // glitch is shorter than the debounce time
    repeat (DEB_LIMIT + 8) begin
      @(negedge clk_100mhz_buf);
      compare_value("led", led, 0);
    end
    repeat (3) begin
      v = $random(seed);
      set_switches(v);
    end
    print_result("debounce", e);
  endtask

  task automatic measure_ticks();
    int e, n, k;
    e = errors;
    wait_for_pulse(SEL_TICK, 2 * TICK, "chip8_tick", n);
    repeat (4) begin
      wait_for_pulse(SEL_TICK, 2 * TICK, "chip8_tick", n);
      compare_value("chip8_tick interval", n + 1, TICK);
    end
    @(posedge clk_100mhz_buf);
    step_mode <= 1'b1;
    repeat (3) @(posedge clk_100mhz_buf); // let a last run-mode tick pass
    repeat (3) begin
      @(posedge clk_100mhz_buf);
      step_btn <= 1'b1;
      count_pulses(SEL_TICK, PRESS_CYCLES, n);
      @(posedge clk_100mhz_buf);
      step_btn <= 1'b0;
      count_pulses(SEL_TICK, PRESS_CYCLES, k);
      compare_value("chip8_tick per press", n, 1);
      compare_value("chip8_tick after release", k, 0);
    end
    @(posedge clk_100mhz_buf);
    step_mode <= 1'b0;
    print_result("tick", e);
  endtask

  task automatic poll_requests();
    int e, n;
    key_vec_t v;
    e = errors;
    repeat (2) begin
      v = $random(seed);
      @(posedge clk_100mhz_buf);
      check_req = 1'b0;
      set_switches(v);
      @(posedge clk_100mhz_buf);
      expected_keys = v;
      check_req = 1'b1;
      count_pulses(SEL_REQ, 3 * POLL, n);
      compare_value("dbg_mem_req count", n, 3);
    end
    // drop ready just after a request and well away from the next poll
    wait_for_pulse(SEL_REQ, 2 * POLL, "dbg_mem_req", n);
    @(posedge clk_100mhz_buf);
    dbg_mem_ready <= 1'b0;
    count_pulses(SEL_REQ, 3 * POLL, n);
    compare_value("dbg_mem_req count while not ready", n, 0);
    @(posedge clk_100mhz_buf);
    dbg_mem_ready <= 1'b1;
    check_req = 1'b0;
    print_result("poll", e);
  endtask

  task automatic scan_display();
    int e, n;
    key_vec_t v;
    e = errors;
    repeat (2) begin
      v = $random(seed);
      set_switches(v);
      @(posedge clk_100mhz_buf);
      wait_for_pulse(SEL_REQ, 2 * POLL, "dbg_mem_req", n);
      wait_for_pulse(SEL_RESP, 8, "dbg_mem_resp", n);
      @(posedge clk_100mhz_buf);
      disp_exp = {2'b00, v[15:14], v[11:0], expected_word(v[11:0], v[15:14])};
      seen_digits = '0;
      check_disp = 1'b1;
      repeat (8 * SCAN) @(negedge clk_100mhz_buf); // one full refresh
      @(posedge clk_100mhz_buf);
      check_disp = 1'b0;
      checks++;
      assert (seen_digits == 8'hFF) else begin
        errors++;
        $display("display scan lit only digits %b", seen_digits);
      end
    end
    print_result("display", e);
  endtask

  // memory model answers three cycles after each request
  always @(posedge clk_100mhz_buf) begin
    if (sys_rst) begin
      req_pipe     <= '0;
      dbg_mem_resp <= 1'b0;
    end else begin
      req_pipe     <= {req_pipe[0], dbg_mem_req};
      dbg_mem_resp <= req_pipe[1];
      if (dbg_mem_req) pend_word <= expected_word(dbg_mem_addr, dbg_mem_type);
      if (req_pipe[1]) dbg_mem_data <= pend_word;
    end
  end

  always @(negedge clk_100mhz_buf) begin
    if (check_req && dbg_mem_req) begin
      compare_value("dbg_mem_addr", dbg_mem_addr, expected_keys[11:0]);
      compare_value("dbg_mem_type", dbg_mem_type, expected_keys[15:14]);
    end
    if (check_disp) begin
      for (int i = 0; i < `SEG_DIGITS; i++) begin
        if (ss_an[i] == 1'b0) dig = i; // the lit digit
      end
      compare_value("ss_c", ss_c, hex_segments(disp_exp[dig*4 +: 4]));
      seen_digits[dig] = 1'b1;
    end
  end

  initial begin
    sys_rst       = 1'b1;
    sw            = '0;
    step_btn      = 1'b0;
    step_mode     = 1'b0;
    dbg_mem_ready = 1'b1;
    reset_behavior();
    debounce_switches();
    measure_ticks();
    poll_requests();
    scan_display();
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (2 * TEST_CYCLES) @(posedge clk_100mhz_buf);
    $display("watchdog expired, run did not finish within %0d cycles", 2 * TEST_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* chip8_panel_top.f */
+incdir+.
panel_pkg.sv
dbg_mem_pkg.sv
debouncer.sv
step_clock_gen.sv
debug_mem_poller.sv
seven_seg_driver.sv
chip8_panel_top.sv
chip8_panel_sva.sv
tb_chip8_panel_top.sv

/* Bender.yml */
package:
  name: chip8_panel

export_include_dirs:
  - .

sources:
  - panel_pkg.sv
  - dbg_mem_pkg.sv
  - debouncer.sv
  - step_clock_gen.sv
  - debug_mem_poller.sv
  - seven_seg_driver.sv
  - chip8_panel_top.sv
  - target: test
    files:
      - chip8_panel_sva.sv
      - tb_chip8_panel_top.sv
